// ==== Makefile ====
# Verilator simulation of the fetch front end

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= fetch_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/fetch_pkg.sv ====
`include "fetch_settings.svh"

package fetch_pkg;

    typedef logic [`AXI_ADDR_WIDTH-1:0]    addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0]    word_t;
    typedef logic [`AXI_RESP_WIDTH-1:0]    resp_t;
    typedef logic [1:0]                    epoch_t;    // bumps on every redirect
    typedef logic [`ICACHE_INDEX_BITS-1:0] cache_index_t;
    typedef logic [`AXI_ADDR_WIDTH-`ICACHE_INDEX_BITS-`ICACHE_OFFSET_BITS-1:0] cache_tag_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // request currently owned by the cache
    typedef struct packed {
        addr_t  pc;
        epoch_t epoch;
    } fetch_tag_t;

    typedef struct packed {
        addr_t pc;
        word_t instr;
        logic  fault;   // bus answered with a non-OKAY code
    } fetch_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MEM_REQ,
        RETURN_DATA
    } icache_state_t;

    typedef enum logic [1:0] {
        REFILL_IDLE,
        REFILL_ADDR,
        REFILL_WAIT,
        REFILL_DONE
    } refill_state_t;

endpackage

// ==== common/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// axi-lite channel widths
`define AXI_ADDR_WIDTH      32
`define AXI_DATA_WIDTH      32
`define AXI_RESP_WIDTH      2

// one word per line, 16 lines
`define ICACHE_OFFSET_BITS  2
`define ICACHE_INDEX_BITS   4

`define FETCH_RESET_PC      32'h0000_1000
`define FETCH_QUEUE_DEPTH   4   // entries toward decode

// 0 turns the cache into a pass-through
`define ICACHE_ON           1

`endif

// ==== fetch_unit.f ====
+incdir+common
common/fetch_pkg.sv
rtl/fetch_pc_gen.sv
icache/icache.sv
rtl/fetch_resp_queue.sv
rtl/fetch_unit.sv
verification/fetch_unit_tb.sv

// ==== icache/icache.sv ====
`timescale 1ns/10ps
`include "fetch_settings.svh"

module icache (
    input  logic             clk,
    input  logic             rst_n,

    // core side AR
    input  fetch_pkg::addr_t raw_fetch_araddr,
    input  logic             raw_fetch_arvalid,
    output logic             raw_fetch_arready,
    // core side R
    output fetch_pkg::word_t raw_fetch_rdata,
    output fetch_pkg::resp_t raw_fetch_rresp,
    output logic             raw_fetch_rvalid,
    input  logic             raw_fetch_rready,

    // bus side AR
    output fetch_pkg::addr_t fetch_araddr,
    output logic             fetch_arvalid,
    input  logic             fetch_arready,
    // bus side R
    input  fetch_pkg::word_t fetch_rdata,
    input  fetch_pkg::resp_t fetch_rresp,
    input  logic             fetch_rvalid,
    output logic             fetch_rready
);
    import fetch_pkg::*;

    generate
        if (`ICACHE_ON != 0) begin : g_cache
            localparam int LINES   = 1 << `ICACHE_INDEX_BITS;
            localparam int TAG_LSB = `ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS;

            icache_state_t    state;
            refill_state_t    refill_state;
            addr_t            addr_q;
            word_t            data_q;
            resp_t            resp_q;
            resp_t            fill_resp_q;

            word_t            data_array [LINES];
            cache_tag_t       tag_array  [LINES];
            logic [LINES-1:0] valid_array;

            cache_index_t     index;
            cache_tag_t       tag;
            logic             cache_hit;
            logic             fill_write;
            logic             load_rsp;

            assign index      = addr_q[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
            assign tag        = addr_q[`AXI_ADDR_WIDTH-1:TAG_LSB];
            assign cache_hit  = valid_array[index] && (tag_array[index] == tag);
            assign fill_write = (refill_state == REFILL_WAIT) && fetch_rvalid;
            assign load_rsp   = ((state == LOOKUP) && cache_hit) ||
                                ((state == MEM_REQ) && (refill_state == REFILL_DONE));

            // lookup side
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    state <= IDLE;
                end else begin
                    case (state)
                        IDLE: begin
                            if (raw_fetch_arvalid) begin
                                state <= LOOKUP;
                            end
                        end
                        LOOKUP: begin
                            state <= cache_hit ? RETURN_DATA : MEM_REQ;
                        end
                        MEM_REQ: begin
                            if (refill_state == REFILL_DONE) begin
                                state <= RETURN_DATA;
                            end
                        end
                        RETURN_DATA: begin
                            if (raw_fetch_rready) begin
                                state <= IDLE;
                            end
                        end
                        default: begin
                            state <= IDLE;
                        end
                    endcase
                end
            end

            // refill side, one bus read at a time
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    refill_state <= REFILL_IDLE;
                    valid_array  <= '0;
                end else begin
                    case (refill_state)
                        REFILL_IDLE: begin
                            if ((state == LOOKUP) && !cache_hit) begin
                                refill_state <= REFILL_ADDR;
                            end
                        end
                        REFILL_ADDR: begin
                            if (fetch_arready) begin
                                refill_state <= REFILL_WAIT;
                            end
                        end
                        REFILL_WAIT: begin
                            if (fetch_rvalid) begin
                                refill_state       <= REFILL_DONE;
                                valid_array[index] <= (fetch_rresp == RESP_OKAY);  // errors stay uncached
                            end
                        end
                        REFILL_DONE: begin
                            refill_state <= REFILL_IDLE;
                        end
                        default: begin
                            refill_state <= REFILL_IDLE;
                        end
                    endcase
                end
            end

            always_ff @(posedge clk) begin
                if (raw_fetch_arvalid && raw_fetch_arready) begin
                    addr_q <= raw_fetch_araddr;
                end
                if (fill_write) begin
                    data_array[index] <= fetch_rdata;
                    tag_array[index]  <= tag;
                    fill_resp_q       <= fetch_rresp;
                end
                if (load_rsp) begin
                    data_q <= data_array[index];
                    resp_q <= (state == LOOKUP) ? RESP_OKAY : fill_resp_q;
                end
            end

            assign raw_fetch_arready = (state == IDLE);
            assign raw_fetch_rdata   = data_q;
            assign raw_fetch_rresp   = resp_q;
            assign raw_fetch_rvalid  = (state == RETURN_DATA);
            assign fetch_araddr      = addr_q;
            assign fetch_arvalid     = (refill_state == REFILL_ADDR);
            assign fetch_rready      = (refill_state == REFILL_WAIT);
        end else begin : g_bypass
            assign fetch_araddr      = raw_fetch_araddr;
            assign fetch_arvalid     = raw_fetch_arvalid;
            assign raw_fetch_arready = fetch_arready;
            assign raw_fetch_rdata   = fetch_rdata;
            assign raw_fetch_rresp   = fetch_rresp;
            assign raw_fetch_rvalid  = fetch_rvalid;
            assign fetch_rready      = raw_fetch_rready;
        end
    endgenerate

endmodule

// ==== rtl/fetch_pc_gen.sv ====
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_pc_gen (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  redirect_valid,
    input  fetch_pkg::addr_t      redirect_pc,
    output fetch_pkg::addr_t      araddr,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic                  rsp_done,
    output fetch_pkg::fetch_tag_t inflight,
    output fetch_pkg::epoch_t     cur_epoch
);
    import fetch_pkg::*;

    addr_t      pc_q;           // address presented or about to be
    epoch_t     epoch_q;
    epoch_t     req_epoch_q;    // epoch of the presented request
    logic       arvalid_q;
    logic       busy_q;         // request owned by the cache
    fetch_tag_t inflight_q;
    logic       redir_pend_q;
    addr_t      redir_pc_q;

    logic   ar_hs;
    logic   slot_free;
    epoch_t epoch_nxt;
    addr_t  pc_after_hs;

    assign ar_hs     = arvalid_q && arready;
    assign slot_free = !busy_q || rsp_done;
    assign epoch_nxt = redirect_valid ? epoch_q + epoch_t'(1) : epoch_q;

    // where to go once the presented address is taken
    always_comb begin
        if (redirect_valid) begin
            pc_after_hs = redirect_pc;
        end else if (redir_pend_q) begin
            pc_after_hs = redir_pc_q;
        end else begin
            pc_after_hs = pc_q + addr_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q         <= `FETCH_RESET_PC;
            epoch_q      <= '0;
            arvalid_q    <= 1'b0;
            busy_q       <= 1'b0;
            redir_pend_q <= 1'b0;
        end else begin
            epoch_q <= epoch_nxt;
            if (ar_hs) begin
                pc_q         <= pc_after_hs;
                arvalid_q    <= 1'b0;
                busy_q       <= 1'b1;
                redir_pend_q <= 1'b0;
            end else if (arvalid_q) begin
                // address is held until accepted, old request goes stale
                if (redirect_valid) begin
                    redir_pend_q <= 1'b1;
                end
            end else begin
                if (redirect_valid) begin
                    pc_q <= redirect_pc;
                end
                if (slot_free) begin
                    arvalid_q <= 1'b1;
                end
                if (rsp_done) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            inflight_q <= '{pc: pc_q, epoch: req_epoch_q};
        end
        if (!arvalid_q && slot_free) begin
            req_epoch_q <= epoch_nxt;   // sampled as arvalid rises
        end
        if (redirect_valid) begin
            redir_pc_q <= redirect_pc;
        end
    end

    assign araddr    = pc_q;
    assign arvalid   = arvalid_q;
    assign inflight  = inflight_q;
    assign cur_epoch = epoch_q;

endmodule

// ==== rtl/fetch_resp_queue.sv ====
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_resp_queue (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fetch_pkg::word_t      rdata,
    input  fetch_pkg::resp_t      rresp,
    input  logic                  rvalid,
    output logic                  rready,
    input  fetch_pkg::fetch_tag_t inflight,
    input  fetch_pkg::epoch_t     cur_epoch,
    output logic                  rsp_done,
    output fetch_pkg::fetch_rsp_t instr,
    output logic                  instr_valid,
    input  logic                  instr_ready
);
    import fetch_pkg::*;

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_rsp_t       entries [DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;
    epoch_t           epoch_seen_q;

    logic             stale;
    logic             flush;
    logic             full;
    logic             push;
    logic             pop;
    logic [PTR_W-1:0] wr_ptr;
    fetch_rsp_t       new_entry;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign stale       = (inflight.epoch != cur_epoch);
    assign flush       = (cur_epoch != epoch_seen_q);   // redirect just happened
    assign full        = (count_q == CNT_W'(DEPTH));
    assign rready      = !full || stale;   // stale words are swallowed
    assign rsp_done    = rvalid && rready;
    assign push        = rsp_done && !stale;
    assign instr_valid = (count_q != '0) && !flush;
    assign pop         = instr_valid && instr_ready;
    assign instr       = entries[head_q];
    assign wr_ptr      = flush ? '0 : tail_q;

    assign new_entry.pc    = inflight.pc;
    assign new_entry.instr = rdata;
    assign new_entry.fault = (rresp != RESP_OKAY);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            epoch_seen_q <= '0;
        end else begin
            epoch_seen_q <= cur_epoch;
            if (flush) begin
                head_q  <= '0;
                tail_q  <= push ? ptr_inc('0) : '0;
                count_q <= push ? CNT_W'(1) : '0;
            end else begin
                if (push) begin
                    tail_q <= ptr_inc(tail_q);
                end
                if (pop) begin
                    head_q <= ptr_inc(head_q);
                end
                count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= new_entry;
        end
    end

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  redirect_valid,
    input  fetch_pkg::addr_t      redirect_pc,
    // toward decode
    output fetch_pkg::fetch_rsp_t instr,
    output logic                  instr_valid,
    input  logic                  instr_ready,
    // bus read channels
    output fetch_pkg::addr_t      fetch_araddr,
    output logic                  fetch_arvalid,
    input  logic                  fetch_arready,
    input  fetch_pkg::word_t      fetch_rdata,
    input  fetch_pkg::resp_t      fetch_rresp,
    input  logic                  fetch_rvalid,
    output logic                  fetch_rready
);
    import fetch_pkg::*;

    addr_t      raw_fetch_araddr;
    logic       raw_fetch_arvalid;
    logic       raw_fetch_arready;
    word_t      raw_fetch_rdata;
    resp_t      raw_fetch_rresp;
    logic       raw_fetch_rvalid;
    logic       raw_fetch_rready;
    fetch_tag_t inflight;
    epoch_t     cur_epoch;
    logic       rsp_done;

    fetch_pc_gen u_pc_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .araddr         (raw_fetch_araddr),
        .arvalid        (raw_fetch_arvalid),
        .arready        (raw_fetch_arready),
        .rsp_done       (rsp_done),
        .inflight       (inflight),
        .cur_epoch      (cur_epoch)
    );

    icache u_icache (
        .clk               (clk),
        .rst_n             (rst_n),
        .raw_fetch_araddr  (raw_fetch_araddr),
        .raw_fetch_arvalid (raw_fetch_arvalid),
        .raw_fetch_arready (raw_fetch_arready),
        .raw_fetch_rdata   (raw_fetch_rdata),
        .raw_fetch_rresp   (raw_fetch_rresp),
        .raw_fetch_rvalid  (raw_fetch_rvalid),
        .raw_fetch_rready  (raw_fetch_rready),
        .fetch_araddr      (fetch_araddr),
        .fetch_arvalid     (fetch_arvalid),
        .fetch_arready     (fetch_arready),
        .fetch_rdata       (fetch_rdata),
        .fetch_rresp       (fetch_rresp),
        .fetch_rvalid      (fetch_rvalid),
        .fetch_rready      (fetch_rready)
    );

    fetch_resp_queue u_resp_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .rdata       (raw_fetch_rdata),
        .rresp       (raw_fetch_rresp),
        .rvalid      (raw_fetch_rvalid),
        .rready      (raw_fetch_rready),
        .inflight    (inflight),
        .cur_epoch   (cur_epoch),
        .rsp_done    (rsp_done),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready)
    );

endmodule

// ==== verification/fetch_unit_tb.sv ====
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_unit_tb;
    import fetch_pkg::*;

    localparam int CYCLE_LIMIT = 20000;   // roughly ten times the directed tests

    logic       clk = 1'b0;
    logic       rst_n;
    logic       redirect_valid;
    addr_t      redirect_pc;
    fetch_rsp_t instr;
    logic       instr_valid;
    logic       instr_ready;
    addr_t      fetch_araddr;
    logic       fetch_arvalid;
    logic       fetch_arready;
    word_t      fetch_rdata;
    resp_t      fetch_rresp;
    logic       fetch_rvalid;
    logic       fetch_rready;

    // bus model state
    int         bus_state;
    int         bus_wait;
    addr_t      bus_addr;
    addr_t      bus_log[$];      // every accepted bus AR
    logic       shadow_valid [1 << `ICACHE_INDEX_BITS];
    cache_tag_t shadow_tag   [1 << `ICACHE_INDEX_BITS];
    logic       check_hits;
    int         hit_violations;

    int         cycle_count = 0;
    int         stall_left;
    int         tests_run;
    int         tests_failed;

    fetch_unit u_fetch_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .instr          (instr),
        .instr_valid    (instr_valid),
        .instr_ready    (instr_ready),
        .fetch_araddr   (fetch_araddr),
        .fetch_arvalid  (fetch_arvalid),
        .fetch_arready  (fetch_arready),
        .fetch_rdata    (fetch_rdata),
        .fetch_rresp    (fetch_rresp),
        .fetch_rvalid   (fetch_rvalid),
        .fetch_rready   (fetch_rready)
    );

    always #4 clk = ~clk;

    function automatic word_t mem_word(input addr_t a);
        return a ^ 32'hA5A5_0000;
    endfunction

    function automatic logic in_err_window(input addr_t a);
        return (a >= 32'h0000_3000) && (a <= 32'h0000_30FF);
    endfunction

    function automatic cache_tag_t tag_of(input addr_t a);
        return cache_tag_t'(a >> (`ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS));
    endfunction

    // line already filled with an OKAY word at this address
    function automatic logic line_resident(input addr_t a);
        cache_index_t idx;
        idx = a[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
        return shadow_valid[idx] && (shadow_tag[idx] == tag_of(a));
    endfunction

    // bus slave serving one read at a time after 1..6 cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            fetch_arready <= 1'b1;
            fetch_rvalid  <= 1'b0;
            bus_state     <= 0;
            for (int i = 0; i < (1 << `ICACHE_INDEX_BITS); i++) begin
                shadow_valid[i] <= 1'b0;
            end
        end else begin
            case (bus_state)
                0: begin
                    if (fetch_arvalid && fetch_arready) begin
                        bus_addr      <= fetch_araddr;
                        bus_wait      <= 1 + int'($urandom % 6);
                        fetch_arready <= 1'b0;
                        bus_state     <= 1;
                        bus_log.push_back(fetch_araddr);
                        if (check_hits && line_resident(fetch_araddr)) begin
                            $display("bus read at %h although that line is cached", fetch_araddr);
                            hit_violations <= hit_violations + 1;
                        end
                    end
                end
                1: begin
                    if (bus_wait <= 1) begin
                        fetch_rvalid <= 1'b1;
                        fetch_rdata  <= mem_word(bus_addr);
                        fetch_rresp  <= in_err_window(bus_addr) ? RESP_SLVERR : RESP_OKAY;
                        bus_state    <= 2;
                    end else begin
                        bus_wait <= bus_wait - 1;
                    end
                end
                default: begin
                    if (fetch_rvalid && fetch_rready) begin
                        fetch_rvalid  <= 1'b0;
                        fetch_arready <= 1'b1;
                        bus_state     <= 0;
                        shadow_valid[bus_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS]] <=
                            !in_err_window(bus_addr);
                        shadow_tag[bus_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS]] <=
                            tag_of(bus_addr);
                    end
                end
            endcase
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // one decode handshake with ready driven at posedge and the word sampled at negedge
    task automatic take_word(input logic stall, output fetch_rsp_t w);
        logic got;
        got = 1'b0;
        while (!got) begin
            @(posedge clk);
            if (stall && stall_left > 0) begin
                instr_ready <= 1'b0;
                stall_left  = stall_left - 1;
            end else begin
                instr_ready <= 1'b1;
                if (stall && ($urandom % 5) == 0) begin
                    stall_left = 16 + int'($urandom % 48);   // long enough to fill the queue
                end
            end
            @(negedge clk);
            if (instr_valid && instr_ready) begin
                w   = instr;
                got = 1'b1;
            end
        end
    endtask

    task automatic do_redirect(input addr_t target);
        @(posedge clk);
        redirect_valid <= 1'b1;
        redirect_pc    <= target;
        instr_ready    <= 1'b0;
        @(posedge clk);
        redirect_valid <= 1'b0;
    endtask

    task automatic expect_stream(input addr_t start, input int n, input logic stall,
                                 input logic fault_exp, inout int errs);
        fetch_rsp_t w;
        addr_t      pc_exp;
        stall_left = 0;
        for (int k = 0; k < n; k++) begin
            pc_exp = start + addr_t'(4 * k);
            take_word(stall, w);
            if (w.pc !== pc_exp) begin
                $display("FAILED instr.pc exp %h got %h", pc_exp, w.pc);
                errs++;
            end
            if (w.fault !== fault_exp) begin
                $display("FAILED instr.fault exp %h got %h", fault_exp, w.fault);
                errs++;
            end
            if (!fault_exp && w.instr !== mem_word(pc_exp)) begin
                $display("FAILED instr.instr exp %h got %h", mem_word(pc_exp), w.instr);
                errs++;
            end
        end
    endtask

    // bus reads since mark that fall inside an n-word loop at lo
    function automatic int count_reads(input int mark, input addr_t lo, input int n);
        int cnt;
        cnt = 0;
        for (int i = mark; i < bus_log.size(); i++) begin
            if (bus_log[i] >= lo && bus_log[i] < lo + addr_t'(4 * n)) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    task automatic check_reads(input int got, input int exp, inout int errs);
        if (got != exp) begin
            $display("FAILED bus read count exp %h got %h", exp, got);
            errs++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("PASSED %s", name);
        end else begin
            tests_failed++;
            $display("FAILED %s, %0d mismatches", name, errs);
        end
    endtask

    task automatic test_seq_from_reset();
        int errs;
        errs = 0;
        expect_stream(`FETCH_RESET_PC, 16, 1'b0, 1'b0, errs);
        report_test("sequential fetch from reset", errs);
    endtask

    task automatic test_hits_after_refill();
        int errs;
        int mark;
        int viol;
        int reads;
        errs       = 0;
        mark       = bus_log.size();
        viol       = hit_violations;
        check_hits = 1'b1;
        do_redirect(`FETCH_RESET_PC);
        expect_stream(`FETCH_RESET_PC, 16, 1'b0, 1'b0, errs);
        check_hits = 1'b0;
        if (hit_violations != viol) begin
            errs++;
        end
        // only lines displaced by the run-ahead fetch may be read again
        reads = count_reads(mark, `FETCH_RESET_PC, 16);
        if (reads > 2) begin
            $display("FAILED bus read count exp 2 or less got %h", reads);
            errs++;
        end
        report_test("hits after refill", errs);
    endtask

    task automatic test_conflict_eviction();
        int errs;
        int mark;
        errs = 0;
        mark = bus_log.size();
        do_redirect(32'h0000_2000);
        expect_stream(32'h0000_2000, 16, 1'b0, 1'b0, errs);
        check_reads(count_reads(mark, 32'h0000_2000, 16), 16, errs);
        mark = bus_log.size();
        do_redirect(32'h0000_1000);
        expect_stream(32'h0000_1000, 16, 1'b0, 1'b0, errs);
        check_reads(count_reads(mark, 32'h0000_1000, 16), 16, errs);
        report_test("conflict eviction", errs);
    endtask

    task automatic test_redirect_flush();
        int errs;
        errs = 0;
        do_redirect(32'h0000_1000);
        expect_stream(32'h0000_1000, 4 + int'($urandom % 6), 1'b0, 1'b0, errs);
        // let old-path words pile up in the queue before redirecting
        @(posedge clk);
        instr_ready <= 1'b0;
        repeat (80) @(posedge clk);
        do_redirect(32'h0000_1800);
        expect_stream(32'h0000_1800, 8, 1'b0, 1'b0, errs);
        report_test("redirect flush", errs);
    endtask

    task automatic test_back_pressure();
        int errs;
        errs = 0;
        do_redirect(32'h0000_1400);
        expect_stream(32'h0000_1400, 40, 1'b1, 1'b0, errs);
        report_test("back-pressure", errs);
    endtask

    task automatic test_bus_error();
        int errs;
        int mark;
        errs = 0;
        mark = bus_log.size();
        do_redirect(32'h0000_3000);
        expect_stream(32'h0000_3000, 4, 1'b0, 1'b1, errs);
        check_reads(count_reads(mark, 32'h0000_3000, 4), 4, errs);
        mark = bus_log.size();
        do_redirect(32'h0000_3000);
        expect_stream(32'h0000_3000, 4, 1'b0, 1'b1, errs);
        check_reads(count_reads(mark, 32'h0000_3000, 4), 4, errs);   // faults never cached
        report_test("bus error", errs);
    endtask

    initial begin
        void'($urandom(77836));
        rst_n          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        instr_ready    = 1'b0;
        fetch_arready  = 1'b0;
        fetch_rvalid   = 1'b0;
        fetch_rdata    = '0;
        fetch_rresp    = '0;
        check_hits     = 1'b0;
        hit_violations = 0;
        tests_run      = 0;
        tests_failed   = 0;
        stall_left     = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        test_seq_from_reset();
        test_hits_after_refill();
        test_conflict_eviction();
        test_redirect_flush();
        test_back_pressure();
        test_bus_error();

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
